//--- build.f
src/rom_bus_pkg.sv
src/rom_client_pkg.sv
src/rom_req_cache.sv
src/rom_latency_timer.sv
src/rom_array.sv
src/rom_fetch_fsm.sv
src/rom_fetch_top.sv
test/rom_fetch_tb.sv

//--- run.sh
#!/bin/sh
# build the rom fetch testbench with verilator and run it from the project root
verilator --binary --timing -f build.f --top-module rom_fetch_tb -o rom_fetch_sim || exit 1
out=$(./obj_dir/rom_fetch_sim)
echo "$out"
echo "$out" | grep -qx "test passed" && echo "simulation ok" || { echo "simulation bad"; exit 1; }

//--- src/rom_array.sv
/* ROM array
   synchronous 32-word rom, read on cen, contents from a hex image */

`timescale 1ns/100ps

module rom_array
    import rom_bus_pkg::*;
(
    input  logic               clk,
    input  logic               cen,
    input  logic [ROM_WAW-1:0] rom_addr,
    output rom_word_t          rom_data
);

    logic [31:0] mem [0:ROM_WORDS-1];

    // image shared with the testbench
    initial begin
        $readmemh("test/rom_words.hex", mem);
    end

    // registered read, one cen cycle
    always_ff @(posedge clk) begin
        if (cen) begin
            rom_data <= mem[rom_addr];
        end
    end

endmodule

//--- src/rom_bus_pkg.sv
/* ROM bus definitions
   word geometry, access latency, the word view and the fill path back to a cache */

package rom_bus_pkg;

    // rom geometry
    localparam int ROM_WORDS = 32;
    localparam int ROM_WAW   = 5;
    // byte address, two bits below the word address
    localparam int ROM_BAW   = 7;

    // cen cycles from timer start to data valid
    localparam int ROM_LATENCY = 3;

    // one rom word, seen as bytes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
    } rom_word_t;

    // word returned to a single cache
    typedef struct packed {
        logic      we;
        rom_word_t data;
    } rom_fill_t;

endpackage

//--- src/rom_client_pkg.sv
/* ROM client definitions
   slot count and the request structs on the client side of the caches */

package rom_client_pkg;

    import rom_bus_pkg::*;

    // slot 0 is 8 bit, slot 1 is 16 bit
    localparam int SLOTS = 2;

    // cache to fsm, held until the fill lands
    typedef struct packed {
        logic               req;
        logic [ROM_BAW-1:0] addr;
    } rom_req_t;

    // outside world into a cache
    typedef struct packed {
        logic [ROM_BAW-1:0] addr;
        logic               addr_ok;
    } client_in_t;

endpackage

//--- src/rom_fetch_fsm.sv
/* ROM fetch FSM
   grants the lowest missing slot, waits out the rom access and returns the word */

`timescale 1ns/100ps

module rom_fetch_fsm
    import rom_bus_pkg::*, rom_client_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cen,
    input  rom_req_t           rq [SLOTS],
    input  logic               done,
    input  rom_word_t          rom_data,
    output logic               start,
    output logic [ROM_WAW-1:0] rom_addr,
    output rom_fill_t          fill [SLOTS]
);

    localparam int SW = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_FILL
    } state_t;

    state_t        state;
    logic [SW-1:0] slot;
    logic [SW-1:0] pick;
    logic          any_req;

    // fixed priority with slot 0 first
    always_comb begin
        any_req = 1'b0;
        pick    = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (rq[i].req) begin
                any_req = 1'b1;
                pick    = SW'(i);
            end
        end
    end

    // timer kicks off in the grant cycle
    assign start = (state == ST_IDLE) && any_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            slot  <= '0;
        end else if (cen) begin
            case (state)
                ST_IDLE: begin
                    if (any_req) begin
                        slot  <= pick;
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (done) begin
                        state <= ST_FILL;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // word address held for the whole access
    always_ff @(posedge clk) begin
        if (cen && start) begin
            rom_addr <= rq[pick].addr[ROM_BAW-1:2];
        end
    end

    // fill strobe to the granted slot only
    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            fill[i].we   = (state == ST_FILL) && (slot == SW'(i));
            fill[i].data = rom_data;
        end
    end

    // granted client still misses the word on rom_addr when the strobe goes out
    a_fill_target: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_FILL) |->
            (rq[slot].req && (rq[slot].addr[ROM_BAW-1:2] == rom_addr)))
        else $error("fill strobe for a slot that no longer requests the fetched word");

endmodule

//--- src/rom_fetch_top.sv
/* ROM fetch subsystem
   two client caches sharing one slow rom through the fetch FSM and timer */

`timescale 1ns/100ps

module rom_fetch_top
    import rom_bus_pkg::*, rom_client_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cen,
    input  client_in_t       client [SLOTS],
    output logic [7:0]       slot0_dout,
    output logic [15:0]      slot1_dout,
    output logic [SLOTS-1:0] busy
);

    rom_req_t           rq [SLOTS];
    rom_fill_t          fill [SLOTS];
    logic               start;
    logic               done;
    logic [ROM_WAW-1:0] rom_addr;
    rom_word_t          rom_data;

    // byte client, top priority
    rom_req_cache #(.DW(8)) u_cache0 (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .client(client[0]), .fill(fill[0]), .rq(rq[0]), .dout(slot0_dout)
    );

    // halfword client
    rom_req_cache #(.DW(16)) u_cache1 (
        .clk(clk), .rst_n(rst_n), .cen(cen),
        .client(client[1]), .fill(fill[1]), .rq(rq[1]), .dout(slot1_dout)
    );

    rom_fetch_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .cen(cen), .rq(rq), .done(done),
        .rom_data(rom_data), .start(start), .rom_addr(rom_addr), .fill(fill)
    );

    rom_latency_timer u_timer (
        .clk(clk), .rst_n(rst_n), .cen(cen), .start(start), .done(done)
    );

    rom_array u_rom (
        .clk(clk), .cen(cen), .rom_addr(rom_addr), .rom_data(rom_data)
    );

    // busy is the raw miss level
    assign busy[0] = rq[0].req;
    assign busy[1] = rq[1].req;

endmodule

//--- src/rom_latency_timer.sv
/* ROM latency timer
   counts the rom access time in cen cycles and flags its last cycle */

`timescale 1ns/100ps

module rom_latency_timer
    import rom_bus_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic cen,
    input  logic start,
    output logic done
);

    localparam int CW = $clog2(ROM_LATENCY + 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cen) begin
            if (start) begin
                cnt <= CW'(ROM_LATENCY);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // last cen cycle of the access
    assign done = (cnt == CW'(1));

    // fsm must not restart an access still in flight
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && start) |-> (cnt == '0))
        else $error("timer restarted while counting");

endmodule

//--- src/rom_req_cache.sv
/* Two-entry ROM request cache
   keeps two rom words, asks for missing ones, returns a byte, halfword or word */

`timescale 1ns/100ps

module rom_req_cache
    import rom_bus_pkg::*, rom_client_pkg::*;
#(
    parameter int DW = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cen,
    input  client_in_t    client,
    input  rom_fill_t     fill,
    output rom_req_t      rq,
    output logic [DW-1:0] dout
);

    logic [ROM_BAW-1:0] aligned;
    logic [ROM_BAW-1:0] tag0;
    logic [ROM_BAW-1:0] tag1;
    rom_word_t          data0;
    rom_word_t          data1;
    rom_word_t          sel;
    logic               hit0;
    logic               hit1;
    logic               init;
    // entry to replace on the next fill
    logic               victim;

    if (!(DW == 8 || DW == 16 || DW == 32)) begin : g_bad_dw
        $error("rom_req_cache supports DW of 8, 16 or 32 only");
    end

    // word aligned lookup
    assign aligned = {client.addr[ROM_BAW-1:2], 2'b00};
    assign hit0    = (aligned == tag0);
    assign hit1    = (aligned == tag1);

    // tags are unknown until the first fill, init covers that
    assign rq.req  = init | (~(hit0 | hit1) & client.addr_ok);
    assign rq.addr = aligned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init   <= 1'b1;
            victim <= 1'b0;
        end else if (cen && fill.we) begin
            init <= 1'b0;
            // first fill seeds both entries, pointer stays on entry 0
            if (!init) begin
                victim <= ~victim;
            end
        end
    end

    // payload, written only on a fill strobe
    always_ff @(posedge clk) begin
        if (cen && fill.we) begin
            if (init || !victim) begin
                tag0  <= aligned;
                data0 <= fill.data;
            end
            if (init || victim) begin
                tag1  <= aligned;
                data1 <= fill.data;
            end
        end
    end

    assign sel = hit0 ? data0 : data1;

    // output sampled only while the data is there
    if (DW == 8) begin : g_byte
        always_ff @(posedge clk) begin
            if (!rq.req) begin
                dout <= sel.b[client.addr[1:0]];
            end
        end
    end else if (DW == 16) begin : g_half
        always_ff @(posedge clk) begin
            if (!rq.req) begin
                dout <= sel.h[client.addr[1]];
            end
        end
    end else begin : g_word
        always_ff @(posedge clk) begin
            if (!rq.req) begin
                dout <= sel;
            end
        end
    end

    // a filled address must hit right after the fsm strobe
    a_fill_clears_req: assert property (@(posedge clk) disable iff (!rst_n)
        (cen && fill.we) ##1 $stable(client.addr) |-> !rq.req)
        else $error("req still high after fill of unchanged address");

endmodule

//--- test/rom_fetch_tb.sv
/* ROM fetch subsystem testbench
   table of client reads checked against a reference copy of the rom image */

`timescale 1ns/100ps

module rom_fetch_tb
    import rom_bus_pkg::*, rom_client_pkg::*;
();

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 2;
    // client addresses held through reset, these become the init fills
    localparam logic [ROM_BAW-1:0] INIT_A0 = 7'h04;
    localparam logic [ROM_BAW-1:0] INIT_A1 = 7'h10;

    // one stimulus row, miss bits are the expected busy behavior per slot
    typedef struct packed {
        logic [1:0]         mask;
        logic [ROM_BAW-1:0] a0;
        logic [ROM_BAW-1:0] a1;
        logic               rand_cen;
        logic [1:0]         miss;
    } row_t;

    logic             clk;
    logic             rst_n;
    logic             cen;
    client_in_t       client [SLOTS];
    logic [7:0]       slot0_dout;
    logic [15:0]      slot1_dout;
    logic [SLOTS-1:0] busy;

    logic [31:0] rom_ref [0:ROM_WORDS-1];
    row_t        rows [$];
    string       names [$];
    logic        table_ready;
    logic        rand_mode;
    integer      seed;
    int          errors;
    int          checks;

    rom_fetch_top DUT (
        .clk(clk), .rst_n(rst_n), .cen(cen), .client(client),
        .slot0_dout(slot0_dout), .slot1_dout(slot1_dout), .busy(busy)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // byte lane picked by the two low address bits
    function automatic logic [7:0] ref_byte(input logic [ROM_BAW-1:0] addr);
        logic [31:0] w;
        w = rom_ref[addr[ROM_BAW-1:2]] >> {addr[1:0], 3'b000};
        return w[7:0];
    endfunction

    // halfword picked by address bit 1
    function automatic logic [15:0] ref_half(input logic [ROM_BAW-1:0] addr);
        logic [31:0] w;
        w = rom_ref[addr[ROM_BAW-1:2]] >> {addr[1], 4'b0000};
        return w[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic add_row(input string name, input logic [1:0] mask,
                           input logic [ROM_BAW-1:0] a0, input logic [ROM_BAW-1:0] a1,
                           input logic rnd, input logic [1:0] miss);
        row_t r;
        r.mask     = mask;
        r.a0       = a0;
        r.a1       = a1;
        r.rand_cen = rnd;
        r.miss     = miss;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // falling edge step, cen never low two cycles in a row
    task automatic next_cycle();
        logic [31:0] r;
        @(negedge clk);
        r = $random(seed);
        if (rand_mode && cen) begin
            cen = r[0];
        end else begin
            cen = 1'b1;
        end
    endtask

    task automatic run_row(input int idx);
        row_t       r;
        logic [1:0] seen;
        logic [1:0] pending;
        int         fall [SLOTS];
        int         n;
        r = rows[idx];
        next_cycle();
        rand_mode = r.rand_cen;
        if (r.mask[0]) begin
            client[0].addr    = r.a0;
            client[0].addr_ok = 1'b1;
        end
        if (r.mask[1]) begin
            client[1].addr    = r.a1;
            client[1].addr_ok = 1'b1;
        end
        seen    = 2'b00;
        pending = r.mask;
        n       = 0;
        fall[0] = 0;
        fall[1] = 0;
        // a miss raises busy at once, a hit never does
        while (pending != 2'b00) begin
            next_cycle();
            n++;
            seen = seen | (busy & r.mask);
            for (int s = 0; s < SLOTS; s++) begin
                if (pending[s] && !busy[s]) begin
                    pending[s] = 1'b0;
                    fall[s]    = n;
                end
            end
        end
        // dout registers one clock after busy drops
        next_cycle();
        seen = seen | (busy & r.mask);
        for (int s = 0; s < SLOTS; s++) begin
            if (r.mask[s]) begin
                check_value({names[idx], $sformatf(" miss%0d", s)},
                            32'(r.miss[s]), 32'(seen[s]));
            end
        end
        check_value({names[idx], " slot0 byte"}, 32'(ref_byte(client[0].addr)),
                    32'(slot0_dout));
        check_value({names[idx], " slot1 half"}, 32'(ref_half(client[1].addr)),
                    32'(slot1_dout));
        // fixed priority, slot 0 served first
        if (r.mask == 2'b11 && r.miss == 2'b11) begin
            check_value({names[idx], " fetch order"}, 32'(1), 32'(fall[0] < fall[1]));
        end
    endtask

    initial begin : main
        rst_n             = 1'b0;
        cen               = 1'b1;
        client[0].addr    = INIT_A0;
        client[0].addr_ok = 1'b1;
        client[1].addr    = INIT_A1;
        client[1].addr_ok = 1'b1;
        rand_mode         = 1'b0;
        table_ready       = 1'b0;
        seed              = 96;
        errors            = 0;
        checks            = 0;
        $readmemh("test/rom_words.hex", rom_ref);
        // name, mask, slot0 addr, slot1 addr, random cen, expected miss
        add_row("init_fill",     2'b11, INIT_A0, INIT_A1, 1'b0, 2'b11);
        add_row("repl_b",        2'b01, 7'h09, 7'h00, 1'b0, 2'b01);
        add_row("repl_c",        2'b01, 7'h0e, 7'h00, 1'b0, 2'b01);
        add_row("repl_c_hit",    2'b01, 7'h0f, 7'h00, 1'b0, 2'b00);
        add_row("repl_a_miss",   2'b01, 7'h05, 7'h00, 1'b0, 2'b01);
        add_row("byte_rd",       2'b01, 7'h47, 7'h00, 1'b0, 2'b01);
        add_row("byte_rd_b0",    2'b01, 7'h44, 7'h00, 1'b0, 2'b00);
        add_row("byte_rd_b1",    2'b01, 7'h45, 7'h00, 1'b0, 2'b00);
        add_row("half_rd",       2'b10, 7'h00, 7'h2a, 1'b0, 2'b10);
        add_row("half_rd_lo",    2'b10, 7'h00, 7'h28, 1'b0, 2'b00);
        add_row("same_word",     2'b11, 7'h46, 7'h12, 1'b0, 2'b00);
        add_row("both_miss",     2'b11, 7'h60, 7'h7e, 1'b0, 2'b11);
        add_row("rand_cen_both", 2'b11, 7'h31, 7'h56, 1'b1, 2'b11);
        add_row("rand_cen_hit",  2'b11, 7'h63, 7'h7c, 1'b1, 2'b00);
        add_row("rand_cen_byte", 2'b01, 7'h0b, 7'h00, 1'b1, 2'b01);
        add_row("rand_cen_half", 2'b10, 7'h00, 7'h02, 1'b1, 2'b10);
        table_ready = 1'b1;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // budget per row covers two fetches at half cen rate with margin
    initial begin : watchdog
        longint limit;
        wait (table_ready);
        limit = longint'(rows.size()) * 4 * (ROM_LATENCY + 4) * 2 * CLK_PERIOD
              + longint'(RST_CYCLES * CLK_PERIOD);
        #(limit);
        $display("timeout after %0d ns, the rom fetch subsystem hung with busy high", limit);
        $display("test failed");
        $finish;
    end

endmodule

//--- test/rom_words.hex
// one 32-bit rom word per line, word address 0 to 31
// byte n of word w is {n[1:0], w[4:0], 1'b1}
C1814101
C3834303
C5854505
C7874707
C9894909
CB8B4B0B
CD8D4D0D
CF8F4F0F
D1915111
D3935313
D5955515
D7975717
D9995919
DB9B5B1B
DD9D5D1D
DF9F5F1F
E1A16121
E3A36323
E5A56525
E7A76727
E9A96929
EBAB6B2B
EDAD6D2D
EFAF6F2F
F1B17131
F3B37333
F5B57535
F7B77737
F9B97939
FBBB7B3B
FDBD7D3D
FFBF7F3F
